// ==== src/datapathPkg.sv ====
package datapathPkg;

    // Bus and register file dimensions
    parameter int DATA_WIDTH = 32;
    parameter int NUM_REGS = 16;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [2*DATA_WIDTH-1:0] wideWord_t;
    typedef logic [3:0] regIdx_t;

    // Register fields inside the instruction word
    localparam int RA_HI = 26;
    localparam int RA_LO = 23;
    localparam int RB_HI = 22;
    localparam int RB_LO = 19;
    localparam int RC_HI = 18;
    localparam int RC_LO = 15;
    // Constant field runs from this bit down to bit 0
    localparam int CONST_HI = 18;

    // Bus sources, R0..R15 take numbers 0..15
    localparam int NUM_SOURCES = 22;
    localparam int SRC_HI = 16;
    localparam int SRC_LO = 17;
    localparam int SRC_ZHIGH = 18;
    localparam int SRC_ZLOW = 19;
    localparam int SRC_INPORT = 20;
    localparam int SRC_CONST = 21;
    typedef logic [4:0] srcIdx_t;

endpackage

// ==== src/aluPkg.sv ====
package aluPkg;

    typedef logic [4:0] aluOp_t;

    // Opcode numbers follow the instruction set encoding
    localparam aluOp_t opAdd = 5'd3;
    localparam aluOp_t opSub = 5'd4;
    localparam aluOp_t opAnd = 5'd5;
    localparam aluOp_t opOr = 5'd6;
    localparam aluOp_t opShr = 5'd7;
    localparam aluOp_t opShl = 5'd9;
    localparam aluOp_t opMul = 5'd15;
    localparam aluOp_t opDiv = 5'd16;
    localparam aluOp_t opNeg = 5'd17;
    localparam aluOp_t opNot = 5'd18;

    // Any opcode not listed above makes the ALU output all zeros

endpackage

// ==== src/regBankIf.sv ====
`timescale 1ns/1ns

interface regBankIf #(
    parameter int DATA_WIDTH = datapathPkg::DATA_WIDTH
);
    import datapathPkg::*;

    // One-hot lines from the selector
    logic [NUM_REGS-1:0] regWrite;
    logic [NUM_REGS-1:0] regRead;
    logic baOut;

    // Each slice drives only its own entry
    logic [DATA_WIDTH-1:0] regData [NUM_REGS];
    logic [DATA_WIDTH-1:0] busValue;

    modport selector (output regWrite, output regRead, output baOut);

    modport slice (input regWrite, input baOut, input busValue, output regData);

    modport mux (input regRead, input regData, output busValue);

endinterface

// ==== src/regSelect.sv ====
`timescale 1ns/1ns

module regSelect #(
    parameter int DATA_WIDTH = datapathPkg::DATA_WIDTH
) (
    input  datapathPkg::word_t ir,
    input  logic               gra,
    input  logic               grb,
    input  logic               grc,
    input  logic               rIn,
    input  logic               rOut,
    input  logic               bAOut,
    regBankIf.selector         bank,
    output datapathPkg::word_t cSignExt
);
    import datapathPkg::*;

    regIdx_t selIdx;
    logic fieldValid;
    logic [NUM_REGS-1:0] decoded;

    // Field choice, ra before rb before rc
    always_comb begin
        selIdx = '0;
        if (gra) begin
            selIdx = ir[RA_HI:RA_LO];
        end else if (grb) begin
            selIdx = ir[RB_HI:RB_LO];
        end else if (grc) begin
            selIdx = ir[RC_HI:RC_LO];
        end
    end

    assign fieldValid = gra | grb | grc;

    always_comb begin
        decoded = '0;
        if (fieldValid) begin
            decoded[selIdx] = 1'b1;
        end
    end

    assign bank.regWrite = rIn ? decoded : '0;
    // Base-address read still selects the register, the slice zeroes R0
    assign bank.regRead = (rOut | bAOut) ? decoded : '0;
    assign bank.baOut = bAOut;

    assign cSignExt = {{(DATA_WIDTH - CONST_HI - 1){ir[CONST_HI]}}, ir[CONST_HI:0]};

endmodule

// ==== src/gpRegister.sv ====
`timescale 1ns/1ns

module gpRegister #(
    parameter int DATA_WIDTH = datapathPkg::DATA_WIDTH,
    parameter int REG_INDEX = 0
) (
    input logic     clk,
    input logic     rstN,
    regBankIf.slice bank
);

    logic [DATA_WIDTH-1:0] value;
    logic zeroRead;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            value <= '0;
        end else if (bank.regWrite[REG_INDEX]) begin
            value <= bank.busValue;
        end
    end

    // Only R0 answers a base-address read with zero
    assign zeroRead = (REG_INDEX == 0) && bank.baOut;

    assign bank.regData[REG_INDEX] = zeroRead ? '0 : value;

endmodule

// ==== src/busMux.sv ====
`timescale 1ns/1ns

module busMux #(
    parameter int DATA_WIDTH = datapathPkg::DATA_WIDTH
) (
    regBankIf.mux             bank,
    input datapathPkg::word_t hiData,
    input datapathPkg::word_t loData,
    input datapathPkg::word_t zHighData,
    input datapathPkg::word_t zLowData,
    input datapathPkg::word_t inPortValue,
    input datapathPkg::word_t cSignExt,
    input logic               hiOut,
    input logic               loOut,
    input logic               zHighOut,
    input logic               zLowOut,
    input logic               inPortOut,
    input logic               cOut
);
    import datapathPkg::*;

    logic [NUM_SOURCES-1:0] request;
    logic [DATA_WIDTH-1:0] srcWord [NUM_SOURCES];
    srcIdx_t srcSel;
    logic srcValid;

    // Request bit i belongs to source number i
    assign request = {cOut, inPortOut, zLowOut, zHighOut, loOut, hiOut, bank.regRead};

    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            srcWord[i] = bank.regData[i];
        end
        srcWord[SRC_HI] = hiData;
        srcWord[SRC_LO] = loData;
        srcWord[SRC_ZHIGH] = zHighData;
        srcWord[SRC_ZLOW] = zLowData;
        srcWord[SRC_INPORT] = inPortValue;
        srcWord[SRC_CONST] = cSignExt;
    end

    // Upward scan, so the highest requested number is kept
    always_comb begin
        srcSel = '0;
        srcValid = 1'b0;
        for (int i = 0; i < NUM_SOURCES; i++) begin
            if (request[i]) begin
                srcSel = srcIdx_t'(i);
                srcValid = 1'b1;
            end
        end
    end

    // Idle bus reads as zero
    assign bank.busValue = srcValid ? srcWord[srcSel] : '0;

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu #(
    parameter int DATA_WIDTH = datapathPkg::DATA_WIDTH
) (
    input  datapathPkg::word_t     yValue,
    input  datapathPkg::word_t     busValue,
    input  aluPkg::aluOp_t         opcode,
    output datapathPkg::wideWord_t result
);
    import datapathPkg::*;
    import aluPkg::*;

    localparam int SHIFT_BITS = $clog2(DATA_WIDTH);

    logic [SHIFT_BITS-1:0] shiftAmount;
    word_t quotient;
    word_t remainder;

    function automatic wideWord_t signExtend(input word_t value);
        return {{DATA_WIDTH{value[DATA_WIDTH-1]}}, value};
    endfunction

    assign shiftAmount = busValue[SHIFT_BITS-1:0];

    // Zero divisor leaves both halves at zero
    always_comb begin
        quotient = '0;
        remainder = '0;
        if (busValue != '0) begin
            quotient = $signed(yValue) / $signed(busValue);
            remainder = $signed(yValue) % $signed(busValue);
        end
    end

    always_comb begin
        result = '0;
        case (opcode)
            opAdd: result = signExtend(yValue + busValue);
            opSub: result = signExtend(yValue - busValue);
            opAnd: result = signExtend(yValue & busValue);
            opOr: result = signExtend(yValue | busValue);
            // Shifted word sits in the low half
            opShl: result = {{DATA_WIDTH{1'b0}}, yValue << shiftAmount};
            opShr: result = {{DATA_WIDTH{1'b0}}, yValue >> shiftAmount};
            // Unary ops take only the bus operand
            opNeg: result = signExtend(-busValue);
            opNot: result = signExtend(~busValue);
            opMul: result = $signed(yValue) * $signed(busValue);
            opDiv: result = {remainder, quotient};
            default: result = '0;
        endcase
    end

endmodule

// ==== src/specialRegs.sv ====
`timescale 1ns/1ns

module specialRegs #(
    parameter int DATA_WIDTH = datapathPkg::DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  datapathPkg::word_t     busValue,
    input  datapathPkg::wideWord_t aluResult,
    input  logic                   yEnable,
    input  logic                   zEnable,
    input  logic                   hiEnable,
    input  logic                   loEnable,
    input  logic                   irEnable,
    input  logic                   outPortEnable,
    input  datapathPkg::word_t     inPortData,
    output datapathPkg::word_t     yValue,
    output datapathPkg::word_t     hiData,
    output datapathPkg::word_t     loData,
    output datapathPkg::word_t     zHighData,
    output datapathPkg::word_t     zLowData,
    output datapathPkg::word_t     irValue,
    output datapathPkg::word_t     inPortValue,
    output datapathPkg::word_t     outPortData
);

    logic [2*DATA_WIDTH-1:0] zValue;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            yValue <= '0;
            zValue <= '0;
            hiData <= '0;
            loData <= '0;
            irValue <= '0;
            inPortValue <= '0;
            outPortData <= '0;
        end else begin
            if (yEnable) begin
                yValue <= busValue;
            end
            // Z loads from the ALU, not from the bus
            if (zEnable) begin
                zValue <= aluResult;
            end
            if (hiEnable) begin
                hiData <= busValue;
            end
            if (loEnable) begin
                loData <= busValue;
            end
            if (irEnable) begin
                irValue <= busValue;
            end
            if (outPortEnable) begin
                outPortData <= busValue;
            end
            // Input port has no strobe
            inPortValue <= inPortData;
        end
    end

    assign zHighData = zValue[2*DATA_WIDTH-1:DATA_WIDTH];
    assign zLowData = zValue[DATA_WIDTH-1:0];

endmodule

// ==== src/datapathTop.sv ====
`timescale 1ns/1ns

module datapathTop #(
    parameter int DATA_WIDTH = datapathPkg::DATA_WIDTH
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               gra,
    input  logic               grb,
    input  logic               grc,
    input  logic               rIn,
    input  logic               rOut,
    input  logic               bAOut,
    input  logic               hiOut,
    input  logic               loOut,
    input  logic               zHighOut,
    input  logic               zLowOut,
    input  logic               inPortOut,
    input  logic               cOut,
    input  logic               yEnable,
    input  logic               zEnable,
    input  logic               hiEnable,
    input  logic               loEnable,
    input  logic               irEnable,
    input  logic               outPortEnable,
    input  aluPkg::aluOp_t     opcode,
    input  datapathPkg::word_t inPortData,
    output datapathPkg::word_t outPortData
);
    import datapathPkg::*;

    word_t irValue;
    word_t cSignExt;
    word_t yValue;
    word_t hiData;
    word_t loData;
    word_t zHighData;
    word_t zLowData;
    word_t inPortValue;
    wideWord_t aluResult;

    regBankIf #(.DATA_WIDTH(DATA_WIDTH)) bank ();

    regSelect #(.DATA_WIDTH(DATA_WIDTH)) selector (
        .ir(irValue),
        .gra,
        .grb,
        .grc,
        .rIn,
        .rOut,
        .bAOut,
        .bank(bank.selector),
        .cSignExt
    );

    // Register file slices
    for (genvar i = 0; i < NUM_REGS; i++) begin : gRegs
        gpRegister #(.DATA_WIDTH(DATA_WIDTH), .REG_INDEX(i)) slice (
            .clk,
            .rstN,
            .bank(bank.slice)
        );
    end

    busMux #(.DATA_WIDTH(DATA_WIDTH)) mux (
        .bank(bank.mux),
        .hiData,
        .loData,
        .zHighData,
        .zLowData,
        .inPortValue,
        .cSignExt,
        .hiOut,
        .loOut,
        .zHighOut,
        .zLowOut,
        .inPortOut,
        .cOut
    );

    alu #(.DATA_WIDTH(DATA_WIDTH)) aluUnit (
        .yValue,
        .busValue(bank.busValue),
        .opcode,
        .result(aluResult)
    );

    specialRegs #(.DATA_WIDTH(DATA_WIDTH)) special (
        .clk,
        .rstN,
        .busValue(bank.busValue),
        .aluResult,
        .yEnable,
        .zEnable,
        .hiEnable,
        .loEnable,
        .irEnable,
        .outPortEnable,
        .inPortData,
        .yValue,
        .hiData,
        .loData,
        .zHighData,
        .zLowData,
        .irValue,
        .inPortValue,
        .outPortData
    );

endmodule

// ==== verification/datapathTb.sv ====
`timescale 1ns/1ns

module datapathTb;
    import datapathPkg::*;
    import aluPkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_TEST = 20;
    localparam int NUM_PATTERNS = 23;
    localparam int NUM_COLS = 9;
    localparam int NUM_RANDOM = 10;
    // Reset test reads each general register and counts once per register
    localparam int CYCLE_LIMIT =
        RESET_CYCLES + CYCLES_PER_TEST * (NUM_REGS + NUM_PATTERNS + NUM_RANDOM);

    // Line kinds above the 5-bit opcode range
    localparam word_t KIND_REG = 32'h100;
    localparam word_t KIND_CONST = 32'h101;
    localparam word_t KIND_PRIORITY = 32'h102;

    // Strobe bits in DUT port order
    localparam logic [17:0] GRA = 18'h00001;
    localparam logic [17:0] GRB = 18'h00002;
    localparam logic [17:0] GRC = 18'h00004;
    localparam logic [17:0] RIN = 18'h00008;
    localparam logic [17:0] ROUT = 18'h00010;
    localparam logic [17:0] BAOUT = 18'h00020;
    localparam logic [17:0] HIOUT = 18'h00040;
    localparam logic [17:0] LOOUT = 18'h00080;
    localparam logic [17:0] ZHIGHOUT = 18'h00100;
    localparam logic [17:0] ZLOWOUT = 18'h00200;
    localparam logic [17:0] INPORTOUT = 18'h00400;
    localparam logic [17:0] COUT = 18'h00800;
    localparam logic [17:0] YENABLE = 18'h01000;
    localparam logic [17:0] ZENABLE = 18'h02000;
    localparam logic [17:0] HIENABLE = 18'h04000;
    localparam logic [17:0] LOENABLE = 18'h08000;
    localparam logic [17:0] IRENABLE = 18'h10000;
    localparam logic [17:0] OUTPORTENABLE = 18'h20000;

    logic clk;
    logic rstN;
    logic [17:0] strobes;
    aluOp_t opcode;
    word_t inPortData;
    word_t outPortData;

    word_t patterns [NUM_PATTERNS*NUM_COLS];
    word_t rngState;
    int cycleCount;
    int testCount;
    int failedTests;
    int checkErrors;
    bit testFailed;

    datapathTop #(.DATA_WIDTH(DATA_WIDTH)) i_dut (
        .clk,
        .rstN,
        .gra(strobes[0]),
        .grb(strobes[1]),
        .grc(strobes[2]),
        .rIn(strobes[3]),
        .rOut(strobes[4]),
        .bAOut(strobes[5]),
        .hiOut(strobes[6]),
        .loOut(strobes[7]),
        .zHighOut(strobes[8]),
        .zLowOut(strobes[9]),
        .inPortOut(strobes[10]),
        .cOut(strobes[11]),
        .yEnable(strobes[12]),
        .zEnable(strobes[13]),
        .hiEnable(strobes[14]),
        .loEnable(strobes[15]),
        .irEnable(strobes[16]),
        .outPortEnable(strobes[17]),
        .opcode,
        .inPortData,
        .outPortData
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d clock cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic word_t nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic aluOp_t pickOpcode(input int sel);
        case (sel)
            0: return opAdd;
            1: return opSub;
            2: return opAnd;
            3: return opOr;
            4: return opShl;
            5: return opShr;
            6: return opNeg;
            7: return opNot;
            8: return opMul;
            default: return opDiv;
        endcase
    endfunction

    // 32-bit result sign-extended to 64 bits
    function automatic wideWord_t widen(input int value);
        return longint'(value);
    endfunction

    // Reference ALU with Y as operand a and the bus as operand b
    function automatic wideWord_t modelAlu(input aluOp_t op, input word_t a, input word_t b);
        int sa;
        int sb;
        wideWord_t wide;
        sa = a;
        sb = b;
        wide = '0;
        case (op)
            opAdd: wide = widen(sa + sb);
            opSub: wide = widen(sa - sb);
            opAnd: wide = widen(sa & sb);
            opOr: wide = widen(sa | sb);
            opNeg: wide = widen(-sb);
            opNot: wide = widen(~sb);
            opShl: wide = {32'h0, a << b[4:0]};
            opShr: wide = {32'h0, a >> b[4:0]};
            opMul: wide = longint'(sa) * longint'(sb);
            opDiv: begin
                if (sb != 0) begin
                    wide = {sa % sb, sa / sb};
                end
            end
            default: wide = '0;
        endcase
        return wide;
    endfunction

    task automatic checkWord(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
            checkErrors++;
            testFailed = 1'b1;
        end
    endtask

    task automatic checkWide(input string what, input word_t high, input word_t low,
                             input wideWord_t expected);
        if ({high, low} !== expected) begin
            $display("[FAIL] %0t ns %s: got %h_%h, expected %h", $time, what, high, low,
                     expected);
            checkErrors++;
            testFailed = 1'b1;
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (testFailed) begin
            failedTests++;
            $display("Test %0d %s: failed", testCount, name);
        end else begin
            $display("Test %0d %s: passed", testCount, name);
        end
        testFailed = 1'b0;
    endtask

    // New strobes and input port value from this edge on
    task automatic driveCycle(input logic [17:0] mask, input word_t data);
        @(posedge clk);
        strobes <= mask;
        inPortData <= data;
    endtask

    // Input port register needs one edge before its value reaches the bus
    task automatic busFromInput(input word_t value, input logic [17:0] mask);
        driveCycle('0, value);
        driveCycle(INPORTOUT | mask, value);
    endtask

    task automatic loadIr(input word_t value);
        busFromInput(value, IRENABLE);
    endtask

    task automatic writeReg(input regIdx_t idx, input word_t value);
        loadIr({5'b0, idx, 23'b0});
        busFromInput(value, GRA | RIN);
    endtask

    task automatic readPort(input logic [17:0] mask, output word_t value);
        driveCycle(mask | OUTPORTENABLE, '0);
        driveCycle('0, '0);
        @(negedge clk);
        value = outPortData;
    endtask

    task automatic runResetTest();
        word_t value;
        @(negedge clk);
        checkWord("output port after reset", outPortData, '0);
        readPort('0, value);
        checkWord("idle bus", value, '0);
        for (int i = 0; i < NUM_REGS; i++) begin
            loadIr({5'b0, regIdx_t'(i), 23'b0});
            readPort(GRA | ROUT, value);
            checkWord($sformatf("R%0d after reset", i), value, '0);
        end
        readPort(HIOUT, value);
        checkWord("HI after reset", value, '0);
        readPort(LOOUT, value);
        checkWord("LO after reset", value, '0);
        readPort(ZHIGHOUT, value);
        checkWord("Z high after reset", value, '0);
        readPort(ZLOWOUT, value);
        checkWord("Z low after reset", value, '0);
    endtask

    task automatic runRegTest(input regIdx_t ra, input regIdx_t rc, input word_t a,
                              input word_t expRead, input word_t expBase);
        word_t value;
        writeReg(ra, a);
        loadIr({5'b0, ra, 4'b0, rc, 15'b0});
        readPort(GRC | ROUT, value);
        checkWord("register read", value, expRead);
        readPort(GRC | BAOUT, value);
        checkWord("base-address read", value, expBase);
        // Bus with no read request while the register holds its value
        readPort('0, value);
        checkWord("idle bus with loaded register", value, '0);
    endtask

    task automatic runConstTest(input word_t c, input word_t expected);
        word_t value;
        loadIr({13'b0, c[18:0]});
        readPort(GRC | COUT, value);
        checkWord("constant read", value, expected);
    endtask

    task automatic runPriorityTest(input regIdx_t ra, input word_t a, input logic [17:0] mask,
                                   input word_t c, input word_t expected);
        word_t value;
        writeReg(ra, a);
        loadIr({5'b0, ra, 4'b0, c[18:0]});
        // Input port holds the inverted operand during the read
        driveCycle('0, ~a);
        readPort(mask, value);
        checkWord("priority read", value, expected);
    endtask

    task automatic runAluTest(input aluOp_t op, input regIdx_t ra, input regIdx_t rb,
                              input word_t a, input word_t b, input wideWord_t expected);
        word_t high;
        word_t low;
        writeReg(ra, a);
        writeReg(rb, b);
        opcode <= op;
        loadIr({5'b0, ra, rb, 19'b0});
        driveCycle(GRA | ROUT | YENABLE, '0);
        driveCycle(GRB | ROUT | ZENABLE, '0);
        if (op == opMul || op == opDiv) begin
            driveCycle(ZHIGHOUT | HIENABLE, '0);
            driveCycle(ZLOWOUT | LOENABLE, '0);
            readPort(HIOUT, high);
            readPort(LOOUT, low);
        end else begin
            readPort(ZHIGHOUT, high);
            readPort(ZLOWOUT, low);
        end
        checkWide($sformatf("opcode %0d on %h and %h", op, a, b), high, low, expected);
    endtask

    task automatic runPatternLine(input int line);
        int base;
        word_t kind;
        regIdx_t ra;
        regIdx_t rb;
        regIdx_t rc;
        wideWord_t expected;
        base = line * NUM_COLS;
        kind = patterns[base];
        ra = patterns[base+1][3:0];
        rb = patterns[base+2][3:0];
        rc = patterns[base+3][3:0];
        expected = {patterns[base+7], patterns[base+8]};
        if (kind == KIND_REG) begin
            runRegTest(ra, rc, patterns[base+4], expected[31:0], expected[63:32]);
            finishTest("register transfer");
        end else if (kind == KIND_CONST) begin
            runConstTest(patterns[base+6], expected[31:0]);
            finishTest("constant");
        end else if (kind == KIND_PRIORITY) begin
            runPriorityTest(ra, patterns[base+4], patterns[base+5][17:0], patterns[base+6],
                            expected[31:0]);
            finishTest("bus priority");
        end else begin
            runAluTest(kind[4:0], ra, rb, patterns[base+4], patterns[base+5], expected);
            finishTest($sformatf("ALU opcode %0d", kind));
        end
    endtask

    initial begin
        aluOp_t op;
        word_t a;
        word_t b;
        regIdx_t ra;
        regIdx_t rb;
        bit patternsOk;
        clk = 1'b0;
        rstN = 1'b0;
        strobes = '0;
        opcode = '0;
        inPortData = '0;
        cycleCount = 0;
        testCount = 0;
        failedTests = 0;
        checkErrors = 0;
        testFailed = 1'b0;
        rngState = 32'd66;
        $readmemh("verification/datapathPatterns.txt", patterns);
        // Last line always has a nonzero kind
        patternsOk = (patterns[(NUM_PATTERNS-1)*NUM_COLS] !== '0) &&
                     !$isunknown(patterns[(NUM_PATTERNS-1)*NUM_COLS]);

        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        runResetTest();
        finishTest("reset state");

        if (patternsOk) begin
            for (int n = 0; n < NUM_PATTERNS; n++) begin
                runPatternLine(n);
            end
        end else begin
            $display("Pattern file could not be read or has too few lines");
            checkErrors++;
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            op = pickOpcode(nextRandom() % 10);
            a = nextRandom();
            b = nextRandom();
            ra = regIdx_t'(nextRandom());
            rb = ra + 4'd1;
            runAluTest(op, ra, rb, a, b, modelAlu(op, a, b));
            finishTest($sformatf("random opcode %0d", op));
        end

        $display("Tests %0d, passed %0d, failed %0d, failed checks %0d", testCount,
                 testCount - failedTests, failedTests, checkErrors);
        if (failedTests == 0 && checkErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/datapathPatterns.txt ====
// Columns in hex: kind ra rb rc operandA operandB constant expectHigh expectLow
// Kind 100 register, 101 constant, 102 bus priority (operandB is the strobe mask), else opcode
03 1 2 0 00000005 00000003 00000000 00000000 00000008
03 3 4 0 7FFFFFFF 00000001 00000000 FFFFFFFF 80000000
04 5 6 0 00000003 00000005 00000000 FFFFFFFF FFFFFFFE
05 7 8 0 F0F0F0F0 FF00FF00 00000000 FFFFFFFF F000F000
06 9 A 0 0F0F0000 00000F0F 00000000 00000000 0F0F0F0F
09 B C 0 00000001 00000024 00000000 00000000 00000010
07 D E 0 80000000 0000001F 00000000 00000000 00000001
0F F 0 0 FFFFFFFE 00000003 00000000 FFFFFFFF FFFFFFFA
0F 1 2 0 00010000 00010000 00000000 00000001 00000000
10 3 4 0 FFFFFFF9 00000002 00000000 FFFFFFFF FFFFFFFD
10 5 6 0 00000064 00000007 00000000 00000002 0000000E
10 7 8 0 00000009 00000000 00000000 00000000 00000000
11 9 A 0 12345678 00000005 00000000 FFFFFFFF FFFFFFFB
12 B C 0 00000000 0000FFFF 00000000 FFFFFFFF FFFF0000
01 D E 0 00000005 00000003 00000000 00000000 00000000
100 5 0 5 DEADBEEF 00000000 00000000 DEADBEEF DEADBEEF
100 0 0 0 12345678 00000000 00000000 00000000 12345678
101 0 0 0 00000000 00000000 00012345 00000000 00012345
101 0 0 0 00000000 00000000 0007FFF0 00000000 FFFFFFF0
101 0 0 0 00000000 00000000 00040000 00000000 FFFC0000
102 9 0 0 CAFEF00D 00000811 00000077 00000000 00000077
102 9 0 0 CAFEF00D 00000411 00000000 00000000 35010FF2
102 9 0 0 CAFEF00D 00000FD1 0007FFFF 00000000 FFFFFFFF

// ==== flist.f ====
src/datapathPkg.sv
src/aluPkg.sv
src/regBankIf.sv
src/regSelect.sv
src/gpRegister.sv
src/busMux.sv
src/alu.sv
src/specialRegs.sv
src/datapathTop.sv
verification/datapathTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f flist.f \
    --top-module datapathTb -Mdir obj_dir -o datapathSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/datapathSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1
